// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/csr_pkg.sv
      - rtl/csr_access_if.sv
      - rtl/csr_decoder.sv
      - rtl/csr_counters.sv
      - rtl/csr_file.sv
      - rtl/csr_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_clock_gen.sv
      - testbench/csr_unit_tb.sv

// ==== rtl/csr_access_if.sv ====
// Carries one decoded CSR access from the decoder to the CSR file inside the CSR unit
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

interface csr_access_if;
    import csr_pkg::*;

    // Request side, driven by the decoder
    logic                   req;
    logic [`CSR_ADDR_W-1:0] addr;
    csr_op_e                op;
    logic [`CSR_XLEN-1:0]   wdata;
    logic                   do_write;
    logic                   do_read;
    logic                   bad_op;
    logic [4:0]             rd;

    // Current value at addr, combinational from the file
    logic [`CSR_XLEN-1:0]   rdata;

    modport decoder (
        output req, addr, op, wdata, do_write, do_read, bad_op, rd
    );

    modport file (
        input  req, addr, op, wdata, do_write, do_read, bad_op, rd,
        output rdata
    );

endinterface

`default_nettype wire

// ==== rtl/csr_counters.sv ====
// Zicntr cycle and instret counters feeding the read-only counter CSRs
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        retire,
    output logic [63:0] cycle_count,
    output logic [63:0] instret_count
);

    logic [63:0] cycle_q;
    logic [63:0] instret_q;

    // Free-running cycle count
    // Reads 0 in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q <= 64'd0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
        end
    end

    // One step per retired instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instret_q <= 64'd0;
        end else if (retire) begin
            instret_q <= instret_q + 64'd1;
        end
    end

    assign cycle_count   = cycle_q;
    assign instret_count = instret_q;

    // Cycle moves on every edge once reset is gone
    // time is served from this count, so a stall would show twice
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> cycle_count == $past(cycle_count) + 64'd1)
    else $error("csr_counters: cycle count stalled");

endmodule

`default_nettype wire

// ==== rtl/csr_decoder.sv ====
// Decodes a Zicsr instruction word and its rs1 value into one CSR access request
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  csr_pkg::csr_instr_u  instr,
    input  logic [`CSR_XLEN-1:0] rs1_value,
    csr_access_if.decoder        acc
);
    import csr_pkg::*;

    logic                 use_imm;
    logic [4:0]           src_field;
    logic [`CSR_XLEN-1:0] operand;
    logic [2:0]           funct3;
    csr_op_e              op;

    // Same bits in both views
    assign funct3  = instr.reg_form.funct3;
    assign use_imm = funct3[2];

    // rs1 and zimm share one slot
    assign src_field = instr.reg_form.rs1;

    // Operand depends on the view
    always_comb begin
        if (use_imm) begin
            // zimm is zero-extended
            operand = {{(`CSR_XLEN-5){1'b0}}, instr.imm_form.zimm};
        end else begin
            operand = rs1_value;
        end
    end

    // funct3[1:0] picks the operation
    always_comb begin
        case (funct3[1:0])
            2'b01:   op = CSR_OP_WRITE;
            2'b10:   op = CSR_OP_SET;
            2'b11:   op = CSR_OP_CLEAR;
            default: op = CSR_OP_NONE;
        endcase
    end

    assign acc.req    = instr_valid;
    assign acc.addr   = instr.reg_form.csr;
    assign acc.op     = op;
    assign acc.wdata  = operand;
    assign acc.rd     = instr.reg_form.rd;

    // funct3 000 and 100 carry no CSR operation
    assign acc.bad_op = (op == CSR_OP_NONE);

    // Set/clear with a zero source field has no write side effect
    always_comb begin
        case (op)
            CSR_OP_WRITE:             acc.do_write = 1'b1;
            CSR_OP_SET, CSR_OP_CLEAR: acc.do_write = (src_field != 5'd0);
            default:                  acc.do_write = 1'b0;
        endcase
    end

    // Plain write to x0 skips the read
    assign acc.do_read = (op != CSR_OP_WRITE) || (instr.reg_form.rd != 5'd0);

    // The pipeline only hands over SYSTEM opcode words
    assert property (@(posedge clk) disable iff (!rst_n)
        acc.req |-> instr.reg_form.opcode == 7'b1110011)
    else $error("csr_decoder: request with a non-SYSTEM opcode");

endmodule

`default_nettype wire

// ==== rtl/csr_defines.svh ====
// Data width and CSR address map, included by the CSR package and every CSR RTL block
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Register word width
`define CSR_XLEN 32

// Width of the csr field in the instruction word
`define CSR_ADDR_W 12

// Custom cache flush CSR, bit 0 triggers the flush
`define CSR_ADDR_FLUSH 12'h7C0

// Zicntr low halves
`define CSR_ADDR_CYCLE 12'hC00
`define CSR_ADDR_TIME 12'hC01
`define CSR_ADDR_INSTRET 12'hC02

// Zicntr high halves
`define CSR_ADDR_CYCLEH 12'hC80
`define CSR_ADDR_TIMEH 12'hC81
`define CSR_ADDR_INSTRETH 12'hC82

`endif

// ==== rtl/csr_file.sv ====
// CSR storage with read/modify/write, counter read mux, legality check and registered result
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 rst_n,
    csr_access_if.file           acc,
    input  logic [63:0]          cycle_count,
    input  logic [63:0]          instret_count,
    output logic                 rd_valid,
    output logic [4:0]           rd_index,
    output logic [`CSR_XLEN-1:0] rd_data,
    output logic                 illegal,
    output logic                 flush_cache_flag
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] flush_q;
    logic [`CSR_XLEN-1:0] flush_d;
    logic [`CSR_XLEN-1:0] new_value;
    logic                 ro_write;
    logic                 is_illegal;
    logic                 write_en;

    // Read mux, old value at the requested address
    // time has no separate source and mirrors cycle
    always_comb begin
        case (acc.addr)
            `CSR_ADDR_FLUSH:    acc.rdata = flush_q;
            `CSR_ADDR_CYCLE:    acc.rdata = cycle_count[31:0];
            `CSR_ADDR_CYCLEH:   acc.rdata = cycle_count[63:32];
            `CSR_ADDR_TIME:     acc.rdata = cycle_count[31:0];
            `CSR_ADDR_TIMEH:    acc.rdata = cycle_count[63:32];
            `CSR_ADDR_INSTRET:  acc.rdata = instret_count[31:0];
            `CSR_ADDR_INSTRETH: acc.rdata = instret_count[63:32];
            // Unmapped addresses read as zero
            default:            acc.rdata = '0;
        endcase
    end

    // Modified value from the old one
    always_comb begin
        case (acc.op)
            CSR_OP_WRITE: new_value = acc.wdata;
            CSR_OP_SET:   new_value = acc.rdata | acc.wdata;
            CSR_OP_CLEAR: new_value = acc.rdata & ~acc.wdata;
            default:      new_value = acc.rdata;
        endcase
    end

    // Top two address bits 11 mark a read-only CSR
    assign ro_write   = acc.do_write && (acc.addr[11:10] == 2'b11);
    assign is_illegal = acc.req && (acc.bad_op || ro_write);
    assign write_en   = acc.req && !is_illegal && acc.do_write;

    // Flush CSR next state
    always_comb begin
        if (flush_cache_flag) begin
            // Self-clear during the pulse, writes dropped
            flush_d = '0;
        end else if (write_en && (acc.addr == `CSR_ADDR_FLUSH)) begin
            flush_d = new_value;
        end else begin
            flush_d = flush_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_q <= '0;
        end else begin
            flush_q <= flush_d;
        end
    end

    // Pulse comes straight from bit 0
    assign flush_cache_flag = flush_q[0];

    // Result status, one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            rd_valid <= acc.req && !is_illegal;
            illegal  <= is_illegal;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        rd_index <= acc.rd;
        // Dropped read returns zero
        rd_data  <= acc.do_read ? acc.rdata : '0;
    end

    // Flush pulse lasts one cycle, the self-clear wins over new writes
    assert property (@(posedge clk) disable iff (!rst_n)
        flush_cache_flag |=> !flush_cache_flag)
    else $error("csr_file: flush_cache_flag high for two cycles");

    // An access either completes or traps
    assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_valid && illegal))
    else $error("csr_file: rd_valid and illegal together");

endmodule

`default_nettype wire

// ==== rtl/csr_pkg.sv ====
// Shared CSR types, imported by the decoder, the access interface and the CSR file
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

    // Operation after decode
    // Encoding follows funct3[1:0] so the decoder maps it directly
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    // Register form, source taken from rs1
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] csr;
        logic [4:0]             rs1;
        logic [2:0]             funct3;
        logic [4:0]             rd;
        logic [6:0]             opcode;
    } csr_reg_form_t;

    // Immediate form, same bit positions
    // The rs1 slot holds a 5-bit unsigned immediate
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] csr;
        logic [4:0]             zimm;
        logic [2:0]             funct3;
        logic [4:0]             rd;
        logic [6:0]             opcode;
    } csr_imm_form_t;

    // One instruction word, two readings
    // funct3[2] set selects the immediate view
    typedef union packed {
        csr_reg_form_t reg_form;
        csr_imm_form_t imm_form;
    } csr_instr_u;

endpackage

`default_nettype wire

// ==== rtl/csr_unit.sv ====
// Top of the CSR unit, takes one CSR instruction per cycle from the core pipeline
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    // Instruction from the pipeline
    input  logic                 instr_valid,
    input  logic [31:0]          instr,
    input  logic [`CSR_XLEN-1:0] rs1_value,
    // Retire strobe for instret
    input  logic                 retire,
    // Result back to the register file
    output logic                 rd_valid,
    output logic [4:0]           rd_index,
    output logic [`CSR_XLEN-1:0] rd_data,
    output logic                 illegal,
    // Cache flush request
    output logic                 flush_cache_flag
);

    logic [63:0] cycle_count;
    logic [63:0] instret_count;

    // One access per cycle, decoder to file
    csr_access_if acc_if ();

    csr_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .acc         (acc_if.decoder)
    );

    csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .retire        (retire),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

    csr_file u_file (
        .clk              (clk),
        .rst_n            (rst_n),
        .acc              (acc_if.file),
        .cycle_count      (cycle_count),
        .instret_count    (instret_count),
        .rd_valid         (rd_valid),
        .rd_index         (rd_index),
        .rd_data          (rd_data),
        .illegal          (illegal),
        .flush_cache_flag (flush_cache_flag)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_access_if.sv
rtl/csr_decoder.sv
rtl/csr_counters.sv
rtl/csr_file.sv
rtl/csr_unit.sv
testbench/tb_clock_gen.sv
testbench/csr_unit_tb.sv

// ==== testbench/csr_unit_tb.sv ====
// Testbench for the CSR unit, drives CSR instructions and checks every result cycle against a model
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_unit_tb;

    localparam int         WAIT_LIMIT = 20;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [11:0] COUNTER_ADDRS [6] = '{`CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH,
        `CSR_ADDR_TIME, `CSR_ADDR_TIMEH, `CSR_ADDR_INSTRET, `CSR_ADDR_INSTRETH};

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_value;
    logic        retire;
    logic        rd_valid;
    logic [4:0]  rd_index;
    logic [31:0] rd_data;
    logic        illegal;
    logic        flush_cache_flag;

    // Model state
    logic [31:0] model_flush;
    logic [63:0] model_cycle;
    logic [63:0] model_instret;

    int error_count;
    int check_count;
    int test_count;
    int failed_tests;
    int test_errors_start;
    int flag_cycles;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csr_unit u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .rs1_value        (rs1_value),
        .retire           (retire),
        .rd_valid         (rd_valid),
        .rd_index         (rd_index),
        .rd_data          (rd_data),
        .illegal          (illegal),
        .flush_cache_flag (flush_cache_flag)
    );

    // SYSTEM opcode word from its fields
    function automatic logic [31:0] encode_csr(input logic [11:0] addr, input logic [4:0] src,
                                               input logic [2:0] funct3, input logic [4:0] rd);
        return {addr, src, funct3, rd, OPC_SYSTEM};
    endfunction

    // Old value at addr as the model sees it
    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            `CSR_ADDR_FLUSH:                   return model_flush;
            `CSR_ADDR_CYCLE, `CSR_ADDR_TIME:   return model_cycle[31:0];
            `CSR_ADDR_CYCLEH, `CSR_ADDR_TIMEH: return model_cycle[63:32];
            `CSR_ADDR_INSTRET:                 return model_instret[31:0];
            `CSR_ADDR_INSTRETH:                return model_instret[63:32];
            default:                           return 32'd0;
        endcase
    endfunction

    // One clock edge of the reference, expected outputs after it
    function automatic void csr_model_step(
        input  logic        valid,
        input  logic [31:0] word,
        input  logic [31:0] src_value,
        input  logic        ret,
        output logic        exp_valid,
        output logic [4:0]  exp_index,
        output logic [31:0] exp_data,
        output logic        exp_illegal,
        output logic        exp_flush
    );
        logic [2:0]  funct3;
        logic [4:0]  field;
        logic [31:0] old_value;
        logic [31:0] operand;
        logic [31:0] next_value;
        logic        writes;
        logic        reads;
        funct3    = word[14:12];
        field     = word[19:15];
        old_value = model_read(word[31:20]);
        // Immediate form takes zimm, zero-extended
        operand   = funct3[2] ? {27'd0, field} : src_value;
        // Set/clear with x0 or zimm 0 never write, write to x0 never reads
        writes    = (funct3[1:0] == 2'b01) || (funct3[1:0] != 2'b00 && field != 5'd0);
        reads     = (funct3[1:0] != 2'b01) || (word[11:7] != 5'd0);
        case (funct3[1:0])
            2'b01:   next_value = operand;
            2'b10:   next_value = old_value | operand;
            2'b11:   next_value = old_value & ~operand;
            default: next_value = old_value;
        endcase
        exp_illegal = valid && (funct3[1:0] == 2'b00 || (writes && word[31:30] == 2'b11));
        exp_valid   = valid && !exp_illegal;
        exp_index   = word[11:7];
        exp_data    = reads ? old_value : 32'd0;
        // Pulse cycle clears the register and drops writes
        if (model_flush[0]) begin
            model_flush = 32'd0;
        end else if (exp_valid && writes && word[31:20] == `CSR_ADDR_FLUSH) begin
            model_flush = next_value;
        end
        exp_flush     = model_flush[0];
        model_cycle   = model_cycle + 64'd1;
        model_instret = model_instret + {63'd0, ret};
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic drive_csr(input logic [31:0] word, input logic [31:0] src_value);
        @(posedge clk);
        #10;
        instr_valid = 1'b1;
        instr       = word;
        rs1_value   = src_value;
    endtask

    // One instruction, then wait for its result or trap
    task automatic issue_csr(input logic [31:0] word, input logic [31:0] src_value);
        int waited;
        drive_csr(word, src_value);
        @(posedge clk);
        #10;
        instr_valid = 1'b0;
        waited = 0;
        while (!(rd_valid || illegal) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(rd_valid || illegal)) begin
            error_count++;
            $display("Error at %0t ns: no rd_valid or illegal after a CSR instruction", $time);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        // Let the monitor finish the last result
        idle_cycles(2);
        errs = error_count - test_errors_start;
        test_count++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("Test %0d (%s) finished with %0d errors", test_count, name, errs);
        test_errors_start = error_count;
    endtask

    // Monitor, inputs taken at the edge and outputs compared at the following falling edge
    initial begin
        logic        exp_valid;
        logic [4:0]  exp_index;
        logic [31:0] exp_data;
        logic        exp_illegal;
        logic        exp_flush;
        model_flush   = 32'd0;
        model_cycle   = 64'd0;
        model_instret = 64'd0;
        forever begin
            @(posedge clk);
            if (rst_n === 1'b1) begin
                csr_model_step(instr_valid, instr, rs1_value, retire,
                               exp_valid, exp_index, exp_data, exp_illegal, exp_flush);
                @(negedge clk);
                check_value("rd_valid", rd_valid, exp_valid);
                check_value("illegal", illegal, exp_illegal);
                check_value("flush_cache_flag", flush_cache_flag, exp_flush);
                if (exp_valid) begin
                    check_value("rd_index", rd_index, exp_index);
                    check_value("rd_data", rd_data, exp_data);
                end
            end
        end
    end

    // Flush pulse length counter
    always @(negedge clk) begin
        if (flush_cache_flag === 1'b1) begin
            flag_cycles++;
        end
    end

    // Random retire strobe
    always @(posedge clk) begin
        #10;
        retire = (rst_n === 1'b1) ? 1'($urandom % 2) : 1'b0;
    end

    // Hang guard
    initial begin
        #1_000_000;
        $display("Timeout: the simulation did not reach its end in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int         waited;
        int         start_flags;
        logic [2:0] f3;
        logic [4:0] field;
        void'($urandom(32'hd227));
        instr_valid       = 1'b0;
        instr             = 32'd0;
        rs1_value         = 32'd0;
        retire            = 1'b0;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_errors_start = 0;
        flag_cycles       = 0;
        waited = 0;
        while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            error_count++;
            $display("Error: reset was never released");
        end

        // Random ops on the flush CSR, bit 0 kept clear
        for (int i = 0; i < 24; i++) begin
            f3    = {1'($urandom % 2), 2'(1 + $urandom % 3)};
            field = f3[2] ? (5'($urandom % 32) & 5'h1e) : 5'($urandom % 32);
            issue_csr(encode_csr(`CSR_ADDR_FLUSH, field, f3, 5'(1 + $urandom % 31)),
                      $urandom & 32'hffff_fffe);
        end
        report_test("random flush CSR ops");

        // Bit 0 set gives one pulse
        start_flags = flag_cycles;
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd3, 3'b001, 5'd5), $urandom | 32'd1);
        waited = 0;
        while (flag_cycles == start_flags && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        idle_cycles(3);
        check_value("flush_cache_flag cycles", flag_cycles - start_flags, 1);
        // Second write lands in the pulse cycle and is dropped
        drive_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd3, 3'b001, 5'd5), 32'h0000_00ff);
        drive_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd4, 3'b001, 5'd6), 32'h1234_5678);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b010, 5'd7), 32'd0);
        report_test("flush pulse");

        // Zero source and rd = x0 cases
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd9, 3'b001, 5'd1), 32'h5a5a_5a5a);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b010, 5'd2), 32'hffff_fffe);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b011, 5'd3), 32'hffff_ffff);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b110, 5'd4), 32'd0);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b111, 5'd5), 32'd0);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd9, 3'b001, 5'd0), 32'h0f0f_0f0e);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b010, 5'd6), 32'd0);
        report_test("zero source and rd x0");

        // Counter reads with random gaps
        for (int i = 0; i < 18; i++) begin
            idle_cycles($urandom % 4);
            f3 = {1'($urandom % 2), 1'b1, 1'($urandom % 2)};
            issue_csr(encode_csr(COUNTER_ADDRS[i % 6], 5'd0, f3, 5'(8 + i)), $urandom);
        end
        report_test("counter reads");

        // Bad funct3, counter writes, unmapped reads
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd7, 3'b000, 5'd1), $urandom);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd7, 3'b100, 5'd1), $urandom);
        issue_csr(encode_csr(`CSR_ADDR_CYCLE, 5'd7, 3'b001, 5'd2), $urandom);
        issue_csr(encode_csr(`CSR_ADDR_INSTRETH, 5'd7, 3'b010, 5'd3), $urandom);
        issue_csr(encode_csr(`CSR_ADDR_TIME, 5'd7, 3'b111, 5'd4), 32'd0);
        issue_csr(encode_csr(`CSR_ADDR_CYCLEH, 5'd0, 3'b001, 5'd0), 32'd0);
        issue_csr(encode_csr(12'h300, 5'd0, 3'b010, 5'd5), 32'd0);
        issue_csr(encode_csr(12'h7c1, 5'd0, 3'b010, 5'd6), 32'd0);
        issue_csr(encode_csr(12'hc03, 5'd0, 3'b010, 5'd7), 32'd0);
        issue_csr(encode_csr(`CSR_ADDR_FLUSH, 5'd0, 3'b010, 5'd8), 32'd0);
        report_test("illegal and unmapped");

        $display("Tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset source, 100 ns clock with reset held low for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Release a short delay after the edge, same as the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
